/* src/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Machine word and register file addressing
`define DATA_W 32
`define REG_ADDR_W 5

// Fetch address taken out of reset
`define RESET_PC 0

// Return address register written by jal
`define LINK_REG 31

`endif

/* src/mips_pkg.sv */
`include "mips_macros.svh"

package mips_pkg;

    // Opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_JAL   = 6'h03;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct codes
    localparam logic [5:0] F_SLL   = 6'h00;
    localparam logic [5:0] F_SRL   = 6'h02;
    localparam logic [5:0] F_JR    = 6'h08;
    localparam logic [5:0] F_MFHI  = 6'h10;
    localparam logic [5:0] F_MFLO  = 6'h12;
    localparam logic [5:0] F_MULTU = 6'h19;
    localparam logic [5:0] F_ADD   = 6'h20;
    localparam logic [5:0] F_SUB   = 6'h22;
    localparam logic [5:0] F_AND   = 6'h24;
    localparam logic [5:0] F_OR    = 6'h25;
    localparam logic [5:0] F_SLT   = 6'h2a;

    typedef struct packed {
        logic [5:0]             op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } instr_r_t;

    typedef struct packed {
        logic [5:0]             op;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } instr_i_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } instr_j_t;

    // One instruction word seen through each encoding
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_j_t j;
    } instr_u;

    // ALU_ADD is zero so an all-zero control word stays harmless
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6
    } alu_op_e;

    typedef struct packed {
        logic    branch;
        logic    jump;
        logic    jal;
        logic    jr;
        logic    shamt_sel;
        logic    reg_dst;
        logic    we_reg;
        logic    alu_src;
        logic    dm2reg;
        logic    mult_en;
        logic    hilo_high;
        logic    hilo2reg;
        logic    we_dm;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic               we;
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] wdata;
    } dmem_req_t;

endpackage

/* src/control_unit.sv */
`timescale 1ns/10ps

module control_unit
    import mips_pkg::*;
(
    input  instr_u instr,
    output ctrl_t  ctrl
);

    ctrl_t r_ctrl;

    // Function field decode for R-type
    always_comb begin
        r_ctrl = '0;
        case (instr.r.funct)
            F_ADD, F_SUB, F_AND, F_OR, F_SLT: begin
                r_ctrl.reg_dst = 1'b1;
                r_ctrl.we_reg  = 1'b1;
            end
            F_SLL, F_SRL: begin
                r_ctrl.reg_dst   = 1'b1;
                r_ctrl.we_reg    = 1'b1;
                r_ctrl.shamt_sel = 1'b1;
            end
            F_MFHI, F_MFLO: begin
                r_ctrl.reg_dst   = 1'b1;
                r_ctrl.we_reg    = 1'b1;
                r_ctrl.hilo2reg  = 1'b1;
                r_ctrl.hilo_high = (instr.r.funct == F_MFHI);
            end
            F_MULTU: r_ctrl.mult_en = 1'b1;
            F_JR:    r_ctrl.jr = 1'b1;
            default: r_ctrl = '0;
        endcase

        case (instr.r.funct)
            F_SUB:   r_ctrl.alu_op = ALU_SUB;
            F_AND:   r_ctrl.alu_op = ALU_AND;
            F_OR:    r_ctrl.alu_op = ALU_OR;
            F_SLT:   r_ctrl.alu_op = ALU_SLT;
            F_SLL:   r_ctrl.alu_op = ALU_SLL;
            F_SRL:   r_ctrl.alu_op = ALU_SRL;
            default: r_ctrl.alu_op = ALU_ADD;
        endcase
    end

    // Main opcode decode
    always_comb begin
        ctrl = '0;
        case (instr.r.op)
            OP_RTYPE: ctrl = r_ctrl;
            OP_ADDI: begin
                ctrl.we_reg  = 1'b1;
                ctrl.alu_src = 1'b1;
            end
            OP_LW: begin
                ctrl.we_reg  = 1'b1;
                ctrl.alu_src = 1'b1;
                ctrl.dm2reg  = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_src = 1'b1;
                ctrl.we_dm   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            OP_J: ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump   = 1'b1;
                ctrl.jal    = 1'b1;
                ctrl.we_reg = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* src/regfile.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module regfile (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    input  logic [`REG_ADDR_W-1:0] ra3,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`DATA_W-1:0]     wd,
    output logic [`DATA_W-1:0]     rd1,
    output logic [`DATA_W-1:0]     rd2,
    output logic [`DATA_W-1:0]     rd3
);

    logic [`DATA_W-1:0] regs [1 << `REG_ADDR_W];

    // Register 0 is hardwired to zero
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = read_port(ra1);
    assign rd2 = read_port(ra2);
    // Debug view
    assign rd3 = read_port(ra3);

endmodule

/* src/alu.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module alu
    import mips_pkg::*;
(
    input  alu_op_e            op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] y,
    output logic               zero
);

    logic [4:0] shift_amt;

    // For shifts a carries the shift amount and b the value
    assign shift_amt = a[4:0];

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {{(`DATA_W-1){1'b0}}, ($signed(a) < $signed(b))};
            ALU_SLL: y = b << shift_amt;
            ALU_SRL: y = b >> shift_amt;
            default: y = '0;
        endcase
    end

    // beq compares through subtraction
    assign zero = (y == '0);

endmodule

/* src/hilo_multiplier.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module hilo_multiplier (
    input  logic               clk,
    input  logic               reset,
    input  logic               en,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  logic               high,
    output logic [`DATA_W-1:0] y
);

    logic [2*`DATA_W-1:0] product;
    logic [`DATA_W-1:0]   hi;
    logic [`DATA_W-1:0]   lo;

    // Unsigned full-width product
    assign product = a * b;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (en) begin
            {hi, lo} <= product;
        end
    end

    assign y = high ? hi : lo;

endmodule

/* src/datapath.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module datapath
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_t                  ctrl,
    input  instr_u                 instr,
    input  logic [`DATA_W-1:0]     rd_dm,
    input  logic [`REG_ADDR_W-1:0] ra3,
    output logic [`DATA_W-1:0]     pc_current,
    output dmem_req_t              dmem_req,
    output logic [`DATA_W-1:0]     rd3
);

    logic [`DATA_W-1:0]     pc_next;
    logic [`DATA_W-1:0]     pc_plus4;
    logic [`DATA_W-1:0]     sext_imm;
    logic [`DATA_W-1:0]     branch_target;
    logic [`DATA_W-1:0]     jump_target;
    logic                   branch_taken;
    logic [`DATA_W-1:0]     rs_data;
    logic [`DATA_W-1:0]     rt_data;
    logic [`DATA_W-1:0]     alu_a;
    logic [`DATA_W-1:0]     alu_b;
    logic [`DATA_W-1:0]     alu_y;
    logic                   alu_zero;
    logic [`DATA_W-1:0]     hilo_y;
    logic [`REG_ADDR_W-1:0] rf_wa;
    logic [`DATA_W-1:0]     rf_wd;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_current <= `DATA_W'(`RESET_PC);
        end else begin
            pc_current <= pc_next;
        end
    end

    assign pc_plus4      = pc_current + `DATA_W'(4);
    assign sext_imm      = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
    assign branch_target = pc_plus4 + {sext_imm[`DATA_W-3:0], 2'b00};
    assign jump_target   = {pc_plus4[`DATA_W-1:`DATA_W-4], instr.j.target, 2'b00};
    assign branch_taken  = ctrl.branch & alu_zero;

    // jr wins over jumps, jumps over a taken branch
    always_comb begin
        if (ctrl.jr) begin
            pc_next = rs_data;
        end else if (ctrl.jump) begin
            pc_next = jump_target;
        end else if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_comb begin
        if (ctrl.jal) begin
            rf_wa = `REG_ADDR_W'(`LINK_REG);
        end else if (ctrl.reg_dst) begin
            rf_wa = instr.r.rd;
        end else begin
            rf_wa = instr.r.rt;
        end
    end

    // Write-back select
    always_comb begin
        if (ctrl.jal) begin
            rf_wd = pc_plus4;
        end else if (ctrl.hilo2reg) begin
            rf_wd = hilo_y;
        end else if (ctrl.dm2reg) begin
            rf_wd = rd_dm;
        end else begin
            rf_wd = alu_y;
        end
    end

    regfile u_regfile (
        .clk (clk),
        .we  (ctrl.we_reg),
        .ra1 (instr.r.rs),
        .ra2 (instr.r.rt),
        .ra3 (ra3),
        .wa  (rf_wa),
        .wd  (rf_wd),
        .rd1 (rs_data),
        .rd2 (rt_data),
        .rd3 (rd3)
    );

    // Shift amount rides on operand a for sll and srl
    assign alu_a = ctrl.shamt_sel ? {{(`DATA_W-5){1'b0}}, instr.r.shamt} : rs_data;
    assign alu_b = ctrl.alu_src ? sext_imm : rt_data;

    alu u_alu (
        .op   (ctrl.alu_op),
        .a    (alu_a),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    hilo_multiplier u_hilo (
        .clk   (clk),
        .reset (reset),
        .en    (ctrl.mult_en),
        .a     (rs_data),
        .b     (rt_data),
        .high  (ctrl.hilo_high),
        .y     (hilo_y)
    );

    assign dmem_req.we    = ctrl.we_dm;
    assign dmem_req.addr  = alu_y;
    assign dmem_req.wdata = rt_data;

endmodule

/* src/mips_core.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module mips_core
    import mips_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`DATA_W-1:0]     instr,
    output logic [`DATA_W-1:0]     pc_current,
    output dmem_req_t              dmem_req,
    input  logic [`DATA_W-1:0]     rd_dm,
    input  logic [`REG_ADDR_W-1:0] ra3,
    output logic [`DATA_W-1:0]     rd3
);

    ctrl_t  ctrl;
    instr_u instr_word;

    assign instr_word = instr;

    control_unit u_control (
        .instr (instr_word),
        .ctrl  (ctrl)
    );

    datapath u_datapath (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr      (instr_word),
        .rd_dm      (rd_dm),
        .ra3        (ra3),
        .pc_current (pc_current),
        .dmem_req   (dmem_req),
        .rd3        (rd3)
    );

endmodule

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Each test program followed by its expected results
task automatic build_table();
    logic [`DATA_W-1:0] va;
    logic [`DATA_W-1:0] vb;
    logic [4:0]         sh;
    logic [3:0]         w;
    logic [`DATA_W-1:0] addr;
    logic [63:0]        prod;

    open_test("pc_sequence", 1'b1);
    put_instr(itype_word(OP_ADDI, 0, 1, 16'd1));
    put_instr(itype_word(OP_ADDI, 0, 2, 16'd2));
    put_instr(itype_word(OP_ADDI, 1, 3, 16'd5));
    put_halt();
    expect_reg(3, 32'd6);
    expect_halt(32'd12);

    va = sign_extend(16'(lfsr_bits(16)));
    vb = sign_extend(16'(lfsr_bits(16)));
    sh = 5'(lfsr_bits(5));
    open_test("alu_and_shift", 1'b0);
    put_instr(itype_word(OP_ADDI, 0, 1, va[15:0]));
    put_instr(itype_word(OP_ADDI, 0, 2, vb[15:0]));
    put_instr(rtype_word(3, 1, 2, 0, F_ADD));
    put_instr(rtype_word(4, 1, 2, 0, F_SUB));
    put_instr(rtype_word(5, 1, 2, 0, F_AND));
    put_instr(rtype_word(6, 1, 2, 0, F_OR));
    put_instr(rtype_word(7, 1, 2, 0, F_SLT));
    put_instr(rtype_word(8, 0, 1, sh, F_SLL));
    put_instr(rtype_word(9, 0, 1, sh, F_SRL));
    // Register 0 must keep reading zero
    put_instr(itype_word(OP_ADDI, 1, 0, vb[15:0]));
    put_halt();
    expect_reg(3, va + vb);
    expect_reg(4, va - vb);
    expect_reg(5, va & vb);
    expect_reg(6, va | vb);
    expect_reg(7, ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0);
    expect_reg(8, va << sh);
    expect_reg(9, va >> sh);
    expect_reg(0, 32'd0);
    expect_halt(32'd40);

    va = sign_extend(16'(lfsr_bits(16)));
    w = 4'(lfsr_bits(4));
    addr = 32'd8 + {w, 2'b00};
    open_test("load_store", 1'b0);
    put_instr(itype_word(OP_ADDI, 0, 1, 16'd8));
    put_instr(itype_word(OP_ADDI, 0, 2, va[15:0]));
    put_instr(itype_word(OP_SW, 1, 2, {10'd0, w, 2'b00}));
    put_instr(itype_word(OP_LW, 1, 3, {10'd0, w, 2'b00}));
    put_halt();
    expect_mem(addr, va);
    expect_mem(addr + 4, fill_word(addr[7:2] + 6'd1));
    expect_reg(3, va);
    expect_halt(32'd16);

    open_test("branch_jump", 1'b0);
    put_instr(itype_word(OP_ADDI, 0, 1, 16'd5));
    put_instr(itype_word(OP_ADDI, 0, 3, 16'd0));
    put_instr(itype_word(OP_BEQ, 1, 1, 16'd1));
    put_instr(itype_word(OP_ADDI, 0, 3, 16'd1));
    put_instr(itype_word(OP_BEQ, 1, 0, 16'd1));
    put_instr(itype_word(OP_ADDI, 0, 4, 16'd1));
    put_instr(jtype_word(OP_JAL, 26'd8));
    put_halt();
    put_instr(rtype_word(0, 31, 0, 0, F_JR));
    expect_reg(3, 32'd0);
    expect_reg(4, 32'd1);
    expect_reg(31, 32'd28);
    expect_halt(32'd28);

    va = lfsr_bits(32);
    vb = lfsr_bits(32);
    prod = {32'd0, va} * {32'd0, vb};
    open_test("multiply", 1'b0);
    load_constant(1, 3, va);
    load_constant(2, 3, vb);
    put_instr(rtype_word(0, 1, 2, 0, F_MULTU));
    put_instr(rtype_word(4, 0, 0, 0, F_MFHI));
    put_instr(rtype_word(5, 0, 0, 0, F_MFLO));
    put_halt();
    expect_reg(1, va);
    expect_reg(4, prod[63:32]);
    expect_reg(5, prod[31:0]);
    expect_halt(32'd60);
endtask

`endif

/* testbench/tb_mips_core.sv */
`timescale 1ns/10ps
`include "mips_macros.svh"

module tb_mips_core
    import mips_pkg::*;
();

    typedef enum logic [2:0] {E_TEST, E_INSTR, E_REG, E_MEM, E_HALT} entry_kind_e;

    typedef struct packed {
        entry_kind_e        kind;
        logic [31:0]        a;
        logic [`DATA_W-1:0] b;
    } entry_t;

    logic                   clk;
    logic                   reset;
    logic [`DATA_W-1:0]     instr;
    logic [`DATA_W-1:0]     pc_current;
    dmem_req_t              dmem_req;
    logic [`DATA_W-1:0]     rd_dm;
    logic [`REG_ADDR_W-1:0] ra3;
    logic [`DATA_W-1:0]     rd3;

    logic [`DATA_W-1:0] rom [64];
    logic [`DATA_W-1:0] dmem [64];
    logic [`DATA_W-1:0] prog_words [64];
    entry_t             prog_table [$];
    string              test_names [$];
    logic [31:0]        lfsr_state = 32'hc41;
    int                 build_len;
    int                 instr_total;
    int                 prog_len;
    int                 cycle_count;
    int                 cycle_limit;
    int                 checks;
    int                 errors;
    int                 failed_tests;

    mips_core u_dut (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .pc_current (pc_current),
        .dmem_req   (dmem_req),
        .rd_dm      (rd_dm),
        .ra3        (ra3),
        .rd3        (rd3)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Core sees nops while held in reset
    assign instr = reset ? '0 : rom[pc_current[7:2]];
    assign rd_dm = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [`DATA_W-1:0] sign_extend(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [`DATA_W-1:0] fill_word(input logic [5:0] idx);
        return 32'hdead_0000 | {24'd0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [4:0] rd, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] shamt,
                                               input logic [5:0] funct);
        instr_u w;
        w.r = '{op: OP_RTYPE, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: funct};
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        instr_u w;
        w.i = '{op: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic logic [31:0] jtype_word(input logic [5:0] op, input logic [25:0] target);
        instr_u w;
        w.j = '{op: op, target: target};
        return w;
    endfunction

    task automatic open_test(input string name, input bit linear);
        test_names.push_back(name);
        prog_table.push_back(entry_t'{E_TEST, {31'd0, linear}, '0});
        build_len = 0;
    endtask

    task automatic put_instr(input logic [31:0] word);
        prog_table.push_back(entry_t'{E_INSTR, word, '0});
        build_len++;
        instr_total++;
    endtask

    // Jump to its own address
    task automatic put_halt();
        put_instr(jtype_word(OP_J, 26'(build_len)));
    endtask

    task automatic load_constant(input logic [4:0] rd, input logic [4:0] tmp,
                                 input logic [`DATA_W-1:0] value);
        put_instr(itype_word(OP_ADDI, 0, rd, value[31:16]));
        put_instr(rtype_word(rd, 0, rd, 5'd16, F_SLL));
        put_instr(itype_word(OP_ADDI, 0, tmp, value[15:0]));
        put_instr(rtype_word(tmp, 0, tmp, 5'd16, F_SLL));
        put_instr(rtype_word(tmp, 0, tmp, 5'd16, F_SRL));
        put_instr(rtype_word(rd, rd, tmp, 0, F_OR));
    endtask

    task automatic expect_reg(input int r, input logic [`DATA_W-1:0] v);
        prog_table.push_back(entry_t'{E_REG, 32'(r), v});
    endtask

    task automatic expect_mem(input logic [31:0] addr, input logic [`DATA_W-1:0] v);
        prog_table.push_back(entry_t'{E_MEM, addr, v});
    endtask

    task automatic expect_halt(input logic [`DATA_W-1:0] pc);
        prog_table.push_back(entry_t'{E_HALT, '0, pc});
    endtask

    `include "tb_program.svh"

    task automatic check_word(input string name, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_pc(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR pc_current: got %h, expected %h", got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic run_program(input bit linear);
        logic [`DATA_W-1:0] prev;
        logic [`DATA_W-1:0] halt_pc;
        logic [`DATA_W-1:0] exp_pc;
        int                 stable;
        next_cycle();
        reset = 1'b1;
        for (int k = 0; k < 64; k++) begin
            rom[k] = (k < prog_len) ? prog_words[k] : '0;
            dmem[k] = fill_word(6'(k));
        end
        repeat (3) next_cycle();
        reset = 1'b0;
        check_pc(pc_current, `DATA_W'(`RESET_PC));
        halt_pc = `DATA_W'(4 * (prog_len - 1));
        exp_pc = `DATA_W'(`RESET_PC);
        prev = pc_current;
        stable = 0;
        // Halted once the PC holds for two cycles
        while (stable < 2) begin
            next_cycle();
            if (linear) begin
                exp_pc = (exp_pc == halt_pc) ? halt_pc : exp_pc + 4;
                check_pc(pc_current, exp_pc);
            end
            stable = (pc_current == prev) ? stable + 1 : 0;
            prev = pc_current;
        end
    endtask

    task automatic apply_check(input entry_t e);
        case (e.kind)
            E_REG: begin
                next_cycle();
                ra3 = e.a[4:0];
                @(negedge clk);
                check_word($sformatf("rd3 (r%0d)", e.a), rd3, e.b);
            end
            E_MEM: check_word($sformatf("dmem[%h]", e.a), dmem[e.a[7:2]], e.b);
            default: check_pc(pc_current, e.b);
        endcase
    endtask

    task automatic report_test(input int idx, input int n_checks, input int n_errors);
        if (n_errors > 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %s (%0d checks, %0d errors)", idx + 1, test_names[idx],
                 (n_errors == 0) ? "passed" : "failed", n_checks, n_errors);
    endtask

    initial begin : watchdog
        wait (cycle_limit > 0);
        wait (cycle_count >= cycle_limit);
        $display("Timeout: the program did not reach its halt loop within %0d cycles",
                 cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : run_tests
        entry_t e;
        int     test_idx;
        int     chk_start;
        int     err_start;
        bit     ran;
        bit     linear;
        reset = 1'b1;
        ra3 = '0;
        test_idx = -1;
        chk_start = 0;
        err_start = 0;
        ran = 1'b0;
        linear = 1'b0;
        build_table();
        cycle_limit = 4 * instr_total + 50;
        foreach (prog_table[k]) begin
            e = prog_table[k];
            if (e.kind == E_TEST) begin
                if (test_idx >= 0) begin
                    report_test(test_idx, checks - chk_start, errors - err_start);
                end
                test_idx++;
                chk_start = checks;
                err_start = errors;
                prog_len = 0;
                ran = 1'b0;
                linear = e.a[0];
            end else if (e.kind == E_INSTR) begin
                prog_words[prog_len] = e.a;
                prog_len++;
            end else begin
                if (!ran) begin
                    run_program(linear);
                    ran = 1'b1;
                end
                apply_check(e);
            end
        end
        report_test(test_idx, checks - chk_start, errors - err_start);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_names.size(), failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+src
+incdir+testbench
src/mips_pkg.sv
src/control_unit.sv
src/regfile.sv
src/alu.sv
src/hilo_multiplier.sv
src/datapath.sv
src/mips_core.sv
testbench/tb_mips_core.sv
